/* include/control_params.svh */
`ifndef CONTROL_PARAMS_SVH
`define CONTROL_PARAMS_SVH

// widths
`define CU_DATA_W       16
`define CU_OPCODE_W     4
`define CU_REG_SEL_W    4
`define CU_IMM_W        8
`define CU_ALU_OP_W     3
`define CU_STEP_W       3

// opcodes 0 to 11 with the conditional jumps above them
`define CU_OP_SYS       4'd0   // halt, read, write, jump
`define CU_OP_SETN      4'd1
`define CU_OP_LOADN     4'd2
`define CU_OP_STOREN    4'd3
`define CU_OP_MEMR      4'd4   // loadr, storer
`define CU_OP_ADDN      4'd5
`define CU_OP_ADD       4'd6   // add, copy, nop
`define CU_OP_SUB       4'd7   // sub, neg
`define CU_OP_MUL       4'd8
`define CU_OP_DIV       4'd9
`define CU_OP_MOD       4'd10
`define CU_OP_JUMPN     4'd11  // jumpn, call

// alu operation codes
`define CU_ALU_ADD      3'd0
`define CU_ALU_SUB      3'd1
`define CU_ALU_MUL      3'd2
`define CU_ALU_DIV      3'd3
`define CU_ALU_MOD      3'd4

// bit positions in flags_data
`define CU_FLAG_CARRY   2
`define CU_FLAG_ZERO    1
`define CU_FLAG_SIGN    0

// first step after the two fetch steps
`define CU_STEP_EXEC    3'd2

`endif

/* src/control_pkg.sv */
`include "control_params.svh"

package control_pkg;

    // one instruction word read either with three register fields
    // or with an 8-bit immediate in the low byte
    typedef union packed {
        struct packed {
            logic [`CU_OPCODE_W-1:0]  opcode;
            logic [`CU_REG_SEL_W-1:0] rx;
            logic [`CU_REG_SEL_W-1:0] ry;
            logic [`CU_REG_SEL_W-1:0] rz;  // low bits double as subcode
        } r;
        struct packed {
            logic [`CU_OPCODE_W-1:0]  opcode;
            logic [`CU_REG_SEL_W-1:0] rx;
            logic [`CU_IMM_W-1:0]     imm;
        } i;
    } instr_u;

endpackage

/* src/ctrl_word_if.sv */
`timescale 1ns/1ps
`include "control_params.svh"

interface ctrl_word_if;
    logic mar_in;
    logic mdr_in;
    logic mdr_out;
    logic pc_out;
    logic pc_jump;
    logic pc_increment;
    logic tmp0_in;
    logic tmp0_out;
    logic alu_out;
    logic tmp1_in;
    logic tmp1_out;
    logic flags_in;
    logic reg_in;
    logic reg_out;
    logic ir_in;
    logic in_out;
    logic out_in;
    logic halt;
    logic bus_drive;                         // also marks bus_value valid

    logic [`CU_REG_SEL_W-1:0] reg_sel;
    logic                     sel_valid;
    logic [`CU_ALU_OP_W-1:0]  alu_op;
    logic                     op_valid;
    logic [`CU_DATA_W-1:0]    bus_value;

    modport producer (
        output mar_in, mdr_in, mdr_out, pc_out, pc_jump, pc_increment,
        output tmp0_in, tmp0_out, alu_out, tmp1_in, tmp1_out, flags_in,
        output reg_in, reg_out, ir_in, in_out, out_in, halt, bus_drive,
        output reg_sel, sel_valid, alu_op, op_valid, bus_value
    );

    modport buffer (
        input mar_in, mdr_in, mdr_out, pc_out, pc_jump, pc_increment,
        input tmp0_in, tmp0_out, alu_out, tmp1_in, tmp1_out, flags_in,
        input reg_in, reg_out, ir_in, in_out, out_in, halt, bus_drive,
        input reg_sel, sel_valid, alu_op, op_valid, bus_value
    );
endinterface

/* src/microcode_sequencer.sv */
`timescale 1ns/1ps
`include "control_params.svh"

module microcode_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                writing_program,
    input  control_pkg::instr_u ir_data,
    input  logic [2:0]          flags_data,     // carry, zero, sign
    ctrl_word_if.producer       cw
);
    logic [`CU_STEP_W-1:0] step;
    logic [`CU_STEP_W-1:0] exec_step;          // step counted from first execute step
    logic                  last;               // current step ends the instruction
    logic                  take;               // conditional jump taken
    logic                  is_sub;
    logic                  is_mod;
    logic [`CU_DATA_W-1:0] imm_zx;
    logic [`CU_DATA_W-1:0] imm_sx;

    assign exec_step = step - `CU_STEP_EXEC;
    assign is_sub    = (ir_data.r.opcode == `CU_OP_SUB);
    assign is_mod    = (ir_data.r.opcode == `CU_OP_MOD);
    assign imm_zx    = `CU_DATA_W'(ir_data.i.imm);
    assign imm_sx    = `CU_DATA_W'(signed'(ir_data.i.imm));

    // every register select comes with a register read or write
    // and every alu operation with alu_out or a flags capture
    assign cw.sel_valid = cw.reg_in | cw.reg_out;
    assign cw.op_valid  = cw.alu_out | cw.flags_in;

    // jeqz, jnez, jltz, jgtz by the low opcode bits
    always_comb begin
        case (ir_data.r.opcode[1:0])
            2'b00:   take = flags_data[`CU_FLAG_ZERO];
            2'b01:   take = !flags_data[`CU_FLAG_ZERO];
            2'b10:   take = flags_data[`CU_FLAG_SIGN];
            default: take = !flags_data[`CU_FLAG_SIGN] && !flags_data[`CU_FLAG_ZERO];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (!writing_program) begin
            step <= last ? '0 : step + 1'b1;
        end
    end

    always_comb begin
        cw.mar_in       = 1'b0;
        cw.mdr_in       = 1'b0;
        cw.mdr_out      = 1'b0;
        cw.pc_out       = 1'b0;
        cw.pc_jump      = 1'b0;
        cw.pc_increment = 1'b0;
        cw.tmp0_in      = 1'b0;
        cw.tmp0_out     = 1'b0;
        cw.alu_out      = 1'b0;
        cw.tmp1_in      = 1'b0;
        cw.tmp1_out     = 1'b0;
        cw.flags_in     = 1'b0;
        cw.reg_in       = 1'b0;
        cw.reg_out      = 1'b0;
        cw.ir_in        = 1'b0;
        cw.in_out       = 1'b0;
        cw.out_in       = 1'b0;
        cw.halt         = 1'b0;
        cw.bus_drive    = 1'b0;
        cw.reg_sel      = ir_data.r.rx;         // most steps address rx
        cw.alu_op       = `CU_ALU_ADD;
        cw.bus_value    = imm_zx;
        last            = 1'b0;

        if (!writing_program) begin
            case (step)
                3'd0: begin                     // pc to mar
                    cw.pc_out = 1'b1;
                    cw.mar_in = 1'b1;
                end
                3'd1: begin                     // memory word to ir
                    cw.mdr_out      = 1'b1;
                    cw.ir_in        = 1'b1;
                    cw.pc_increment = 1'b1;
                end
                default: begin
                    case (ir_data.r.opcode)
                        `CU_OP_SYS: begin
                            last = 1'b1;
                            case (ir_data.r.rz[1:0])
                                2'b00: cw.halt = 1'b1;
                                2'b01: begin    // read port into rx
                                    cw.in_out = 1'b1;
                                    cw.reg_in = 1'b1;
                                end
                                2'b10: begin    // write rx to port
                                    cw.out_in  = 1'b1;
                                    cw.reg_out = 1'b1;
                                end
                                default: begin  // jump to rx
                                    cw.pc_jump = 1'b1;
                                    cw.reg_out = 1'b1;
                                end
                            endcase
                        end
                        `CU_OP_SETN: begin
                            cw.reg_in    = 1'b1;
                            cw.bus_drive = 1'b1;
                            last         = 1'b1;
                        end
                        `CU_OP_LOADN, `CU_OP_STOREN: begin
                            if (exec_step == 3'd0) begin    // immediate address to mar
                                cw.mar_in    = 1'b1;
                                cw.bus_drive = 1'b1;
                            end else begin
                                last = 1'b1;
                                if (ir_data.r.opcode == `CU_OP_LOADN) begin
                                    cw.mdr_out = 1'b1;
                                    cw.reg_in  = 1'b1;
                                end else begin
                                    cw.mdr_in  = 1'b1;
                                    cw.reg_out = 1'b1;
                                end
                            end
                        end
                        `CU_OP_MEMR: begin
                            if (ir_data.r.rz[1]) begin      // former push/pop slot
                                last = 1'b1;
                            end else if (exec_step == 3'd0) begin
                                cw.mar_in  = 1'b1;          // address from ry
                                cw.reg_sel = ir_data.r.ry;
                                cw.reg_out = 1'b1;
                            end else begin                  // rz[0] picks store
                                cw.mdr_out = !ir_data.r.rz[0];
                                cw.mdr_in  = ir_data.r.rz[0];
                                cw.reg_in  = !ir_data.r.rz[0];
                                cw.reg_out = ir_data.r.rz[0];
                                last       = 1'b1;
                            end
                        end
                        `CU_OP_ADDN: begin
                            case (exec_step)
                                3'd0: begin
                                    cw.bus_value = imm_sx;
                                    cw.bus_drive = 1'b1;
                                    cw.tmp0_in   = 1'b1;
                                end
                                3'd1: begin
                                    cw.reg_out = 1'b1;
                                    cw.tmp1_in = 1'b1;
                                end
                                default: begin
                                    cw.alu_out = 1'b1;
                                    cw.reg_in  = 1'b1;
                                    last       = 1'b1;
                                end
                            endcase
                        end
                        `CU_OP_ADD, `CU_OP_SUB, `CU_OP_MUL, `CU_OP_DIV, `CU_OP_MOD: begin
                            case (exec_step)
                                3'd0: begin     // sub reads ry first and the rest rz
                                    cw.reg_sel = is_sub ? ir_data.r.ry : ir_data.r.rz;
                                    cw.reg_out = 1'b1;
                                    cw.tmp0_in = !is_mod;
                                    cw.tmp1_in = is_mod;
                                end
                                3'd1: begin
                                    cw.reg_sel = is_sub ? ir_data.r.rz : ir_data.r.ry;
                                    cw.reg_out = 1'b1;
                                    cw.tmp0_in = is_mod;
                                    cw.tmp1_in = !is_mod;
                                end
                                default: begin  // result into rx
                                    case (ir_data.r.opcode)
                                        `CU_OP_SUB: cw.alu_op = `CU_ALU_SUB;
                                        `CU_OP_MUL: cw.alu_op = `CU_ALU_MUL;
                                        `CU_OP_DIV: cw.alu_op = `CU_ALU_DIV;
                                        `CU_OP_MOD: cw.alu_op = `CU_ALU_MOD;
                                        default:    cw.alu_op = `CU_ALU_ADD;
                                    endcase
                                    cw.alu_out = 1'b1;
                                    cw.reg_in  = 1'b1;
                                    last       = 1'b1;
                                end
                            endcase
                        end
                        `CU_OP_JUMPN: begin
                            // call saves pc in rx first and jumpn has rx == 0
                            if (ir_data.r.rx != '0 && exec_step == 3'd0) begin
                                cw.pc_out = 1'b1;
                                cw.reg_in = 1'b1;
                            end else begin
                                cw.pc_jump   = 1'b1;
                                cw.bus_drive = 1'b1;
                                last         = 1'b1;
                            end
                        end
                        default: begin  // conditional jumps
                            case (exec_step)
                                3'd0: begin
                                    cw.reg_out = 1'b1;
                                    cw.tmp0_in = 1'b1;
                                end
                                3'd1: begin     // zero into tmp1
                                    cw.bus_value = '0;
                                    cw.bus_drive = 1'b1;
                                    cw.tmp1_in   = 1'b1;
                                end
                                3'd2: cw.flags_in = 1'b1;
                                default: begin
                                    cw.pc_jump   = take;
                                    cw.bus_drive = take;
                                    last         = 1'b1;
                                end
                            endcase
                        end
                    endcase
                end
            endcase
        end
    end
endmodule

/* src/control_register.sv */
`timescale 1ns/1ps
`include "control_params.svh"

module control_register (
    input  logic                     clk,
    input  logic                     rst,
    ctrl_word_if.buffer              cw,
    output logic                     mar_in,
    output logic                     mdr_in,
    output logic                     mdr_out,
    output logic                     pc_out,
    output logic                     pc_jump,
    output logic                     pc_increment,
    output logic                     tmp0_in,
    output logic                     tmp0_out,
    output logic                     alu_out,
    output logic [`CU_ALU_OP_W-1:0]  alu_op,
    output logic                     tmp1_in,
    output logic                     tmp1_out,
    output logic                     flags_in,
    output logic [`CU_REG_SEL_W-1:0] reg_sel,
    output logic                     reg_in,
    output logic                     reg_out,
    output logic                     ir_in,
    output logic                     in_out,
    output logic                     out_in,
    output logic                     halt,
    output logic [`CU_DATA_W-1:0]    bus_data,
    output logic                     bus_drive
);
    // strobes last exactly one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mar_in       <= 1'b0;
            mdr_in       <= 1'b0;
            mdr_out      <= 1'b0;
            pc_out       <= 1'b0;
            pc_jump      <= 1'b0;
            pc_increment <= 1'b0;
            tmp0_in      <= 1'b0;
            tmp0_out     <= 1'b0;
            alu_out      <= 1'b0;
            tmp1_in      <= 1'b0;
            tmp1_out     <= 1'b0;
            flags_in     <= 1'b0;
            reg_in       <= 1'b0;
            reg_out      <= 1'b0;
            ir_in        <= 1'b0;
            in_out       <= 1'b0;
            out_in       <= 1'b0;
            halt         <= 1'b0;
            bus_drive    <= 1'b0;
        end else begin
            mar_in       <= cw.mar_in;
            mdr_in       <= cw.mdr_in;
            mdr_out      <= cw.mdr_out;
            pc_out       <= cw.pc_out;
            pc_jump      <= cw.pc_jump;
            pc_increment <= cw.pc_increment;
            tmp0_in      <= cw.tmp0_in;
            tmp0_out     <= cw.tmp0_out;
            alu_out      <= cw.alu_out;
            tmp1_in      <= cw.tmp1_in;
            tmp1_out     <= cw.tmp1_out;
            flags_in     <= cw.flags_in;
            reg_in       <= cw.reg_in;
            reg_out      <= cw.reg_out;
            ir_in        <= cw.ir_in;
            in_out       <= cw.in_out;
            out_in       <= cw.out_in;
            halt         <= cw.halt;
            bus_drive    <= cw.bus_drive;
        end
    end

    // selects and bus value persist until the next valid word
    always_ff @(posedge clk) begin
        if (cw.sel_valid) reg_sel <= cw.reg_sel;
        if (cw.op_valid) alu_op <= cw.alu_op;
        if (cw.bus_drive) bus_data <= cw.bus_value;
    end
endmodule

/* src/control_unit.sv */
`timescale 1ns/1ps
`include "control_params.svh"

module control_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     writing_program,  // holds the sequence
    input  logic [`CU_DATA_W-1:0]    ir_data,
    input  logic [2:0]               flags_data,       // carry, zero, sign

    // ram
    output logic                     mar_in,
    output logic                     mdr_in,
    output logic                     mdr_out,

    // program counter
    output logic                     pc_out,
    output logic                     pc_jump,
    output logic                     pc_increment,

    // alu
    output logic                     tmp0_in,
    output logic                     tmp0_out,
    output logic                     alu_out,
    output logic [`CU_ALU_OP_W-1:0]  alu_op,
    output logic                     tmp1_in,
    output logic                     tmp1_out,
    output logic                     flags_in,

    // register file
    output logic [`CU_REG_SEL_W-1:0] reg_sel,
    output logic                     reg_in,
    output logic                     reg_out,

    // ir, io, halt
    output logic                     ir_in,
    output logic                     in_out,
    output logic                     out_in,
    output logic                     halt,

    // shared bus
    output logic [`CU_DATA_W-1:0]    bus_data,
    output logic                     bus_drive
);
    ctrl_word_if cw_bus ();

    microcode_sequencer u_sequencer (
        .clk             (clk),
        .rst             (rst),
        .writing_program (writing_program),
        .ir_data         (ir_data),
        .flags_data      (flags_data),
        .cw              (cw_bus)
    );

    control_register u_register (
        .cw (cw_bus),
        .*
    );
endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);  // five cycles in reset
        rst <= 1'b0;
    end
endmodule

/* test/tb_control_unit.sv */
`timescale 1ns/1ps
`include "control_params.svh"

module tb_control_unit;
    import control_pkg::*;

    // bit positions of the strobes in the packed compare vector
    localparam int MAR_IN = 0, MDR_IN = 1, MDR_OUT = 2, PC_OUT = 3, PC_JUMP = 4;
    localparam int PC_INC = 5, TMP0_IN = 6, ALU_OUT = 8, TMP1_IN = 9;
    localparam int FLAGS_IN = 11, REG_IN = 12, REG_OUT = 13, IR_IN = 14;
    localparam int IN_OUT = 15, OUT_IN = 16, HALT = 17, BUS_DRIVE = 18;

    logic clk, rst, writing_program;
    instr_u ir_data;
    logic [2:0] flags_data;
    logic mar_in, mdr_in, mdr_out, pc_out, pc_jump, pc_increment;
    logic tmp0_in, tmp0_out, alu_out, tmp1_in, tmp1_out, flags_in;
    logic reg_in, reg_out, ir_in, in_out, out_in, halt, bus_drive;
    logic [`CU_ALU_OP_W-1:0] alu_op;
    logic [`CU_REG_SEL_W-1:0] reg_sel;
    logic [`CU_DATA_W-1:0] bus_data;

    integer seed;
    logic [2:0] m_step;                    // model step counter
    logic [18:0] exp_s;
    logic [3:0] exp_sel;
    logic [2:0] exp_op;
    logic [15:0] exp_bus;
    logic idle_word;                       // word zeroed by reset or hold
    logic fin;
    int hold_left, active_cnt, done_len, cnt, n;
    bit seen_fetch;
    string tname;

    tb_clock_gen clk_gen_i (.clk(clk), .rst(rst));
    control_unit dut_i (.*);

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [2:0] alu_code(logic [3:0] opc);
        case (opc)
            `CU_OP_SUB: return `CU_ALU_SUB;
            `CU_OP_MUL: return `CU_ALU_MUL;
            `CU_OP_DIV: return `CU_ALU_DIV;
            `CU_OP_MOD: return `CU_ALU_MOD;
            default:    return `CU_ALU_ADD;
        endcase
    endfunction

    // cycles from fetch step 0 back to step 0
    function automatic int expected_len(instr_u ins);
        case (ins.r.opcode)
            `CU_OP_SYS, `CU_OP_SETN:     return 3;
            `CU_OP_LOADN, `CU_OP_STOREN: return 4;
            `CU_OP_MEMR:                 return ins.r.rz[1] ? 3 : 4;
            `CU_OP_JUMPN:                return (ins.r.rx == 4'd0) ? 3 : 4;
            `CU_OP_ADDN, `CU_OP_ADD, `CU_OP_SUB, `CU_OP_MUL, `CU_OP_DIV,
            `CU_OP_MOD:                  return 5;
            default:                     return 6;
        endcase
    endfunction

    function automatic instr_u random_instr();
        instr_u ins;
        ins = 16'($random(seed));
        if (ins.r.opcode == `CU_OP_JUMPN && ins.r.ry[0])
            ins.r.rx = 4'd0;               // plain jumpn half the time
        return ins;
    endfunction

    task automatic predict_word(
        input  logic [2:0]  step,
        input  instr_u      ins,
        input  logic [2:0]  flags,
        output logic [18:0] s,
        output logic [3:0]  sel,
        output logic [2:0]  op,
        output logic [15:0] bus,
        output logic        last
    );
        logic [3:0] opc;
        logic [2:0] e;
        logic ok;
        logic first_is_tmp1;
        opc = ins.r.opcode;
        e = step - 3'd2;
        s = '0;
        sel = ins.r.rx;
        op = `CU_ALU_ADD;
        bus = {8'h00, ins.i.imm};
        last = 1'b0;
        first_is_tmp1 = (opc == `CU_OP_MOD);
        case (opc[1:0])
            2'b00:   ok = flags[`CU_FLAG_ZERO];
            2'b01:   ok = ~flags[`CU_FLAG_ZERO];
            2'b10:   ok = flags[`CU_FLAG_SIGN];
            default: ok = ~flags[`CU_FLAG_SIGN] & ~flags[`CU_FLAG_ZERO];
        endcase
        if (step == 3'd0) begin
            s[PC_OUT] = 1'b1;
            s[MAR_IN] = 1'b1;
        end else if (step == 3'd1) begin
            s[MDR_OUT] = 1'b1;
            s[IR_IN]   = 1'b1;
            s[PC_INC]  = 1'b1;
        end else if (opc == `CU_OP_SYS) begin
            last = 1'b1;
            case (ins.r.rz[1:0])
                2'b00: s[HALT] = 1'b1;
                2'b01: {s[IN_OUT], s[REG_IN]} = 2'b11;
                2'b10: {s[OUT_IN], s[REG_OUT]} = 2'b11;
                default: {s[PC_JUMP], s[REG_OUT]} = 2'b11;
            endcase
        end else if (opc == `CU_OP_SETN) begin
            {s[REG_IN], s[BUS_DRIVE], last} = 3'b111;
        end else if (opc == `CU_OP_LOADN || opc == `CU_OP_STOREN) begin
            if (e == 3'd0) {s[MAR_IN], s[BUS_DRIVE]} = 2'b11;
            else if (opc == `CU_OP_LOADN) {s[MDR_OUT], s[REG_IN], last} = 3'b111;
            else {s[MDR_IN], s[REG_OUT], last} = 3'b111;
        end else if (opc == `CU_OP_MEMR) begin
            if (ins.r.rz[1]) begin
                last = 1'b1;                   // push/pop slot does nothing
            end else if (e == 3'd0) begin
                {s[MAR_IN], s[REG_OUT]} = 2'b11;
                sel = ins.r.ry;
            end else if (ins.r.rz[0]) begin
                {s[MDR_IN], s[REG_OUT], last} = 3'b111;
            end else begin
                {s[MDR_OUT], s[REG_IN], last} = 3'b111;
            end
        end else if (opc == `CU_OP_ADDN) begin
            if (e == 3'd0) begin
                {s[BUS_DRIVE], s[TMP0_IN]} = 2'b11;
                bus = {{8{ins.i.imm[7]}}, ins.i.imm};
            end else if (e == 3'd1) begin
                {s[REG_OUT], s[TMP1_IN]} = 2'b11;
            end else begin
                {s[ALU_OUT], s[REG_IN], last} = 3'b111;
            end
        end else if (opc >= `CU_OP_ADD && opc <= `CU_OP_MOD) begin
            if (e == 3'd0) begin
                sel = (opc == `CU_OP_SUB) ? ins.r.ry : ins.r.rz;
                s[REG_OUT] = 1'b1;
                s[first_is_tmp1 ? TMP1_IN : TMP0_IN] = 1'b1;
            end else if (e == 3'd1) begin
                sel = (opc == `CU_OP_SUB) ? ins.r.rz : ins.r.ry;
                s[REG_OUT] = 1'b1;
                s[first_is_tmp1 ? TMP0_IN : TMP1_IN] = 1'b1;
            end else begin
                op = alu_code(opc);
                {s[ALU_OUT], s[REG_IN], last} = 3'b111;
            end
        end else if (opc == `CU_OP_JUMPN) begin
            if (ins.r.rx != 4'd0 && e == 3'd0) {s[PC_OUT], s[REG_IN]} = 2'b11;
            else {s[PC_JUMP], s[BUS_DRIVE], last} = 3'b111;
        end else begin                         // compare rx with zero and then branch
            case (e)
                3'd0: {s[REG_OUT], s[TMP0_IN]} = 2'b11;
                3'd1: begin
                    {s[BUS_DRIVE], s[TMP1_IN]} = 2'b11;
                    bus = 16'h0000;
                end
                3'd2: s[FLAGS_IN] = 1'b1;
                default: {s[PC_JUMP], s[BUS_DRIVE], last} = {ok, ok, 1'b1};
            endcase
        end
    endtask

    // model and drive on the rising edge and check on the falling edge
    task automatic run_cycle(output logic done);
        logic [18:0] s, act;
        logic [3:0] sel;
        logic [2:0] op;
        logic [15:0] bus;
        logic last;
        integer r;
        @(posedge clk);
        done = 1'b0;
        tname = $sformatf("op%0d step%0d", ir_data.r.opcode, m_step);
        idle_word = rst | writing_program;
        if (rst) m_step = 3'd0;
        if (idle_word) begin
            exp_s = '0;
        end else begin
            predict_word(m_step, ir_data, flags_data, s, sel, op, bus, last);
            exp_s = s;
            if (s[REG_IN] | s[REG_OUT]) exp_sel = sel;
            if (s[ALU_OUT] | s[FLAGS_IN]) exp_op = op;
            if (s[BUS_DRIVE]) exp_bus = bus;
            if (last) begin
                done = 1'b1;
                done_len = expected_len(ir_data);
                m_step = 3'd0;
            end else begin
                m_step = m_step + 3'd1;
            end
            if (m_step == 3'd1) ir_data <= random_instr();
        end
        r = $random(seed);
        flags_data <= r[2:0];
        if (hold_left > 0) hold_left--;
        else if (!rst && m_step == 3'd0 && r[10:8] == 3'd0) hold_left = 1 + r[5:4];
        writing_program <= (hold_left > 0);

        @(negedge clk);
        act = {bus_drive, halt, out_in, in_out, ir_in, reg_out, reg_in, flags_in,
               tmp1_out, tmp1_in, alu_out, tmp0_out, tmp0_in, pc_increment,
               pc_jump, pc_out, mdr_out, mdr_in, mar_in};
        assert (act === exp_s) else begin
            $display("** Error %s strobes: expected %h, actual %h", tname, exp_s, act);
            abort_run();
        end
        if (exp_s[REG_IN] | exp_s[REG_OUT])
            assert (reg_sel === exp_sel) else begin
                $display("** Error %s reg_sel: expected %h, actual %h", tname, exp_sel, reg_sel);
                abort_run();
            end
        if (exp_s[ALU_OUT] | exp_s[FLAGS_IN])
            assert (alu_op === exp_op) else begin
                $display("** Error %s alu_op: expected %h, actual %h", tname, exp_op, alu_op);
                abort_run();
            end
        if (exp_s[BUS_DRIVE])
            assert (bus_data === exp_bus) else begin
                $display("** Error %s bus_data: expected %h, actual %h", tname, exp_bus,
                         bus_data);
                abort_run();
            end
        if (!idle_word) begin              // instruction length between fetch words
            if (act[PC_OUT] && act[MAR_IN]) begin
                if (seen_fetch)
                    assert (active_cnt == done_len) else begin
                        $display("** Error %s length: expected %0d, actual %0d", tname,
                                 done_len, active_cnt);
                        abort_run();
                    end
                seen_fetch = 1'b1;
                active_cnt = 1;
            end else begin
                active_cnt++;
            end
        end
    endtask

    initial begin
        seed = 60358;
        writing_program = 1'b0;
        ir_data = '0;
        flags_data = 3'b000;
        m_step = 3'd0;
        hold_left = 0;
        active_cnt = 0;
        done_len = 0;
        seen_fetch = 1'b0;
        cnt = 0;
        fin = 1'b0;
        while (rst !== 1'b0) begin
            run_cycle(fin);
            cnt++;
            if (cnt > 20) begin
                $display("** Error: reset was never released");
                abort_run();
            end
        end
        for (n = 0; n < 2000; n++) begin
            cnt = 0;
            fin = 1'b0;
            while (!fin) begin
                run_cycle(fin);
                cnt++;
                if (!fin && cnt > 40) begin
                    $display("** Error: instruction %0d never reached its last step", n);
                    abort_run();
                end
            end
        end
        $display("TB PASSED");
        $finish;
    end
endmodule

/* control_unit.f */
+incdir+include
src/control_pkg.sv
src/ctrl_word_if.sv
src/microcode_sequencer.sv
src/control_register.sv
src/control_unit.sv
test/tb_clock_gen.sv
test/tb_control_unit.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f control_unit.f --top-module tb_control_unit -o sim_tb &&
out="$(./obj_dir/sim_tb)" ; echo "$out" &&
echo "$out" | grep -qx "TB PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
